/* logic/psg_defs.svh */
`ifndef PSG_DEFS_SVH
`define PSG_DEFS_SVH

`define PSG_ADDR_W    6
`define PSG_DATA_W    32
`define PSG_PERIOD_W  12
`define PSG_VOL_W     2
`define PSG_PWM_W     6
`define PSG_MID_LEVEL 32   // level with every channel silent

// register map, byte addresses
`define PSG_REG_CTRL  6'h00
`define PSG_REG_CH0   6'h04
`define PSG_REG_CH1   6'h08
`define PSG_REG_CH2   6'h0C
`define PSG_REG_CH3   6'h10

`define PSG_LFSR_SEED 15'h0001
`define PSG_LFSR_TAPS 15'h6000 // x^15 + x^14 + 1, right-shifting galois

`endif

/* logic/psg_pkg.sv */
`include "psg_defs.svh"

package psg_pkg;

  // period in audio ticks minus one
  typedef logic [`PSG_PERIOD_W-1:0] period_t;

  typedef logic [`PSG_VOL_W-1:0] vol_t;

  // mixed level, also the pwm compare value
  typedef logic [`PSG_PWM_W-1:0] level_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

/* logic/psg_chan_if.sv */
interface psg_chan_if
  import psg_pkg::*;
();

  period_t period;
  vol_t    vol;
  logic    enable;
  logic    state;   // square or noise output bit

  modport regs (
    output period, vol, enable
  );

  modport gen (
    input  period, enable,
    output state
  );

  modport mix (
    input vol, enable, state
  );

endinterface

/* logic/psg_axil_regs.sv */
`include "psg_defs.svh"

module psg_axil_regs
  import psg_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`PSG_ADDR_W-1:0]    awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`PSG_DATA_W-1:0]    wdata,
  input  logic [`PSG_DATA_W/8-1:0]  wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [`PSG_ADDR_W-1:0]    araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [`PSG_DATA_W-1:0]    rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  psg_chan_if.regs                  chan [4]
);

  logic [3:0] ctrl_q;       // channel enables
  period_t    period_q [4];
  vol_t       vol_q [4];
  logic [4:0] wr_sel;       // one-hot: ctrl, ch0..ch3
  logic [4:0] rd_sel;
  logic       wr_hs;
  logic       rd_hs;

  function automatic logic [4:0] decode(input logic [`PSG_ADDR_W-1:0] addr);
    logic [4:0] sel;
    sel = '0;
    case (addr)
      `PSG_REG_CTRL: sel[0] = 1'b1;
      `PSG_REG_CH0:  sel[1] = 1'b1;
      `PSG_REG_CH1:  sel[2] = 1'b1;
      `PSG_REG_CH2:  sel[3] = 1'b1;
      `PSG_REG_CH3:  sel[4] = 1'b1;
      default:       sel = '0;    // unmapped or misaligned
    endcase
    return sel;
  endfunction

  function automatic logic [`PSG_DATA_W-1:0] read_word(input logic [4:0] sel);
    logic [`PSG_DATA_W-1:0] word;
    word = '0;
    if (sel[0])
      word[3:0] = ctrl_q;
    for (int i = 0; i < 4; i++) begin
      if (sel[i+1]) begin
        word[11:0]  = period_q[i];
        word[17:16] = vol_q[i];
      end
    end
    return word;
  endfunction

  assign wr_sel = decode(awaddr);
  assign rd_sel = decode(araddr);
  assign wr_hs  = awvalid && awready && wvalid && wready;
  assign rd_hs  = arvalid && arready;

  // write channel, address and data taken together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= RESP_OKAY;
    end else begin
      awready <= 1'b0;
      wready  <= 1'b0;
      if (awvalid && wvalid && !awready && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (wr_hs) begin
        bvalid <= 1'b1;
        bresp  <= (|wr_sel) ? RESP_OKAY : RESP_SLVERR;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
      for (int i = 0; i < 4; i++) begin
        period_q[i] <= '0;
        vol_q[i]    <= '0;
      end
    end else if (wr_hs) begin
      if (wr_sel[0] && wstrb[0])
        ctrl_q <= wdata[3:0];
      for (int i = 0; i < 4; i++) begin
        if (wr_sel[i+1]) begin
          if (wstrb[0]) period_q[i][7:0]  <= wdata[7:0];
          if (wstrb[1]) period_q[i][11:8] <= wdata[11:8];
          if (wstrb[2]) vol_q[i]          <= wdata[17:16];
        end
      end
    end
  end

  // read channel, stalls while rvalid is pending
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rresp   <= RESP_OKAY;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_hs) begin
        rvalid <= 1'b1;
        rresp  <= (|rd_sel) ? RESP_OKAY : RESP_SLVERR;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs)
      rdata <= read_word(rd_sel);   // zero for unmapped
  end

  for (genvar g = 0; g < 4; g++) begin : g_chan
    assign chan[g].period = period_q[g];
    assign chan[g].vol    = vol_q[g];
    assign chan[g].enable = ctrl_q[g];
  end

endmodule

/* logic/psg_tone_bank.sv */
module psg_tone_bank
  import psg_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     tick,    // one clock in 64
  psg_chan_if.gen  chan [3]
);

  for (genvar g = 0; g < 3; g++) begin : g_tone
    period_t cnt_q;
    logic    state_q;

    // period counter, steps once per audio tick
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q   <= '0;
        state_q <= 1'b0;
      end else if (!chan[g].enable) begin
        // key-off, next enable starts as from reset
        cnt_q   <= '0;
        state_q <= 1'b0;
      end else if (tick) begin
        if (cnt_q == chan[g].period) begin
          cnt_q   <= '0;
          state_q <= ~state_q;     // half period done
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end

    assign chan[g].state = state_q;
  end

endmodule

/* logic/psg_noise_chan.sv */
`include "psg_defs.svh"

module psg_noise_chan
  import psg_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    tick,
  psg_chan_if.gen chan
);

  period_t     cnt_q;
  logic [14:0] lfsr_q;
  logic [14:0] lfsr_next;
  logic        state_q;

  // galois step, shift right and fold the taps in on a one
  assign lfsr_next = (lfsr_q >> 1) ^ (lfsr_q[0] ? `PSG_LFSR_TAPS : 15'h0000);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      lfsr_q  <= `PSG_LFSR_SEED;
      state_q <= 1'b0;
    end else if (!chan.enable) begin
      cnt_q   <= '0;
      lfsr_q  <= `PSG_LFSR_SEED;   // re-key from the seed
      state_q <= 1'b0;
    end else if (tick) begin
      if (cnt_q == chan.period) begin
        cnt_q   <= '0;
        lfsr_q  <= lfsr_next;
        state_q <= lfsr_next[0];   // new bit 0 becomes the output
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign chan.state = state_q;

endmodule

/* logic/psg_pwm_mixer.sv */
`include "psg_defs.svh"

module psg_pwm_mixer
  import psg_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  psg_chan_if.mix chan [4],
  output logic    tick,
  output logic    audio
);

  logic [`PSG_PWM_W-1:0] frame_cnt;
  level_t                level_d;
  level_t                level_q;   // held for a whole pwm frame
  logic [3:0]            en;
  logic [3:0]            st;
  vol_t                  vol [4];

  for (genvar g = 0; g < 4; g++) begin : g_unpack
    assign en[g]  = chan[g].enable;
    assign st[g]  = chan[g].state;
    assign vol[g] = chan[g].vol;
  end

  // free running, frame 0 starts at reset release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      frame_cnt <= '0;
    else
      frame_cnt <= frame_cnt + 1'b1;
  end

  assign tick = (frame_cnt == '1);

  // signed sum around mid level; the result always lands in 8..56,
  // so modulo-64 arithmetic gives the exact level
  always_comb begin
    level_t weight;
    level_d = level_t'(`PSG_MID_LEVEL);
    for (int i = 0; i < 4; i++) begin
      weight = level_t'({vol[i], 1'b0});    // 2 x vol
      if (en[i])
        level_d = st[i] ? level_d + weight : level_d - weight;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      level_q <= level_t'(`PSG_MID_LEVEL);
    else if (tick)
      level_q <= level_d;     // states from before this tick's update
  end

  assign audio = (frame_cnt <= level_q);  // level+1 high cycles per frame

endmodule

/* logic/psg_top.sv */
`include "psg_defs.svh"

module psg_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`PSG_ADDR_W-1:0]    awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`PSG_DATA_W-1:0]    wdata,
  input  logic [`PSG_DATA_W/8-1:0]  wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [`PSG_ADDR_W-1:0]    araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [`PSG_DATA_W-1:0]    rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  output logic                      audio
);

  logic tick;

  psg_chan_if chan [4] ();   // 0..2 tone, 3 noise

  psg_axil_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .chan    (chan)
  );

  psg_tone_bank u_tone_bank (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick),
    .chan  (chan[0:2])
  );

  psg_noise_chan u_noise_chan (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick),
    .chan  (chan[3])
  );

  psg_pwm_mixer u_pwm_mixer (
    .clk   (clk),
    .rst_n (rst_n),
    .chan  (chan),
    .tick  (tick),
    .audio (audio)
  );

endmodule

/* sim/psg_chk.sv */
module psg_chk (
  input logic clk,
  input logic rst_n,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic bvalid,
  input logic bready,
  input logic arready,
  input logic rvalid,
  input logic rready
);

  // responses held until taken
  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

  a_bvalid_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
    else $error("bvalid without a write handshake");

  a_reset_low: assert property (@(posedge clk)
    rst_n && !$past(rst_n) |-> !(awready || wready || arready || bvalid || rvalid))
    else $error("control outputs high right after reset");

endmodule

bind psg_axil_regs psg_chk u_chk (.*);

/* sim/psg_tb.sv */
`include "psg_defs.svh"

module psg_tb
  import psg_pkg::*;
();

  logic                     clk;
  logic                     rst_n;
  logic [`PSG_ADDR_W-1:0]   awaddr;
  logic [`PSG_ADDR_W-1:0]   araddr;
  logic                     awvalid;
  logic                     wvalid;
  logic                     bready;
  logic                     arvalid;
  logic                     rready;
  logic [`PSG_DATA_W-1:0]   wdata;
  logic [`PSG_DATA_W/8-1:0] wstrb;
  logic                     awready;
  logic                     wready;
  logic                     bvalid;
  logic                     arready;
  logic                     rvalid;
  logic                     audio;
  logic [1:0]               bresp;
  logic [1:0]               rresp;
  logic [`PSG_DATA_W-1:0]   rdata;

  int err_val = 0;
  int err_to = 0;

  // reference model state
  logic [3:0]  sh_ctrl = '0;
  logic [11:0] sh_per [4] = '{default: '0};
  logic [1:0]  sh_vol [4] = '{default: '0};
  int          m_cnt [4] = '{default: 0};
  logic [3:0]  m_state = '0;
  logic [14:0] m_lfsr = `PSG_LFSR_SEED;
  int          m_frame = 0;
  int          m_level = `PSG_MID_LEVEL;
  logic        pend_valid = 1'b0;
  logic [5:0]  pend_addr;
  logic [31:0] pend_data;
  logic [3:0]  pend_strb;
  logic [15:0] rnd_lfsr = 16'd56;

  psg_top u_psg_top (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // expected frame level from enables, volumes and pre-update states
  function automatic int expected_level(input logic [3:0] en, input logic [7:0] vols,
                                        input logic [3:0] st);
    int lvl;
    lvl = `PSG_MID_LEVEL;
    for (int i = 0; i < 4; i++) begin
      if (en[i])
        lvl = st[i] ? lvl + 2 * int'(vols[2*i+:2]) : lvl - 2 * int'(vols[2*i+:2]);
    end
    return lvl;
  endfunction

  function automatic logic [15:0] rnd_step(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      rnd_lfsr = rnd_step(rnd_lfsr);   // one step per bit
      v = {v[14:0], rnd_lfsr[0]};
    end
  endtask

  task automatic apply_write(input logic [5:0] a, input logic [31:0] d, input logic [3:0] s);
    int idx;
    idx = int'(a[5:2]) - 1;
    if (a == `PSG_REG_CTRL) begin
      if (s[0]) sh_ctrl = d[3:0];
    end else if (a[1:0] == 2'b00 && idx >= 0 && idx < 4) begin
      if (s[0]) sh_per[idx][7:0] = d[7:0];
      if (s[1]) sh_per[idx][11:8] = d[11:8];
      if (s[2]) sh_vol[idx] = d[17:16];
    end
  endtask

  // model of one clock edge that runs just after it
  task automatic model_edge();
    logic [14:0] nxt;
    if (m_frame == 63) begin
      m_level = expected_level(sh_ctrl, {sh_vol[3], sh_vol[2], sh_vol[1], sh_vol[0]},
                               m_state);
      for (int i = 0; i < 4; i++) begin
        if (sh_ctrl[i] && m_cnt[i] == int'(sh_per[i])) begin
          m_cnt[i] = 0;
          if (i < 3) begin
            m_state[i] = ~m_state[i];
          end else begin
            nxt = (m_lfsr >> 1) ^ (m_lfsr[0] ? `PSG_LFSR_TAPS : 15'h0000);
            m_lfsr = nxt;
            m_state[3] = nxt[0];
          end
        end else if (sh_ctrl[i]) begin
          m_cnt[i] = (m_cnt[i] + 1) % (1 << `PSG_PERIOD_W);   // 12-bit counter wraps
        end
      end
    end
    for (int i = 0; i < 4; i++) begin
      if (!sh_ctrl[i]) begin
        m_cnt[i] = 0;
        m_state[i] = 1'b0;
        if (i == 3) m_lfsr = `PSG_LFSR_SEED;
      end
    end
    m_frame = (m_frame + 1) % 64;
    if (pend_valid) begin
      apply_write(pend_addr, pend_data, pend_strb);   // register changed at this edge
      pend_valid = 1'b0;
    end
  endtask

  // counts high cycles per frame and compares them with the model
  initial begin
    int high_cnt;
    high_cnt = 0;
    @(posedge rst_n);
    forever begin
      if (audio) high_cnt++;
      if (m_frame == 63) begin
        if (high_cnt != m_level + 1) begin
          $display("Fail at %0t: frame had %0d high cycles, expected %0d",
                   $time, high_cnt, m_level + 1);
          err_val++;
        end
        high_cnt = 0;
      end
      @(negedge clk);
      model_edge();
    end
  end

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_val++;
    end
  endtask

  task automatic axi_write(input logic [5:0] a, input logic [31:0] d, input logic [3:0] s,
                           input int hold, input logic [1:0] exp_resp);
    int n;
    logic [1:0] resp;
    awaddr = a;
    wdata = d;
    wstrb = s;
    awvalid = 1'b1;
    wvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(awready && wready) && n < 20);
    if (!(awready && wready)) begin
      $display("write to %h was never accepted", a);
      err_to++;
      awvalid = 1'b0;
      wvalid = 1'b0;
      return;
    end
    @(posedge clk);
    pend_addr = a;
    pend_data = d;
    pend_strb = s;
    pend_valid = 1'b1;
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    n = 0;
    while (!bvalid && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!bvalid) begin
      $display("no write response for %h", a);
      err_to++;
      return;
    end
    resp = bresp;
    repeat (hold) begin   // bready held off
      @(negedge clk);
      check_val("bvalid under back-pressure", 32'(bvalid), 32'd1);
      check_val("bresp under back-pressure", 32'(bresp), 32'(resp));
    end
    check_val("bresp", 32'(resp), 32'(exp_resp));
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [5:0] a, input int hold,
                          input logic [1:0] exp_resp, input logic [31:0] exp_data);
    int n;
    logic [31:0] data;
    araddr = a;
    arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!arready && n < 20);
    if (!arready) begin
      $display("read of %h was never accepted", a);
      err_to++;
      arvalid = 1'b0;
      return;
    end
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!rvalid) begin
      $display("no read data for %h", a);
      err_to++;
      return;
    end
    data = rdata;
    repeat (hold) begin
      @(negedge clk);
      check_val("rvalid under back-pressure", 32'(rvalid), 32'd1);
      check_val("rdata under back-pressure", rdata, data);
    end
    check_val("rresp", 32'(rresp), 32'(exp_resp));
    check_val("rdata", data, exp_data);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    repeat (n * 64) @(negedge clk);
  endtask

  task automatic finish_run();
    $display("errors: %0d wrong values, %0d timeouts", err_val, err_to);
    if (err_val == 0 && err_to == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  initial begin
    #1000000;
    $display("simulation ran past its time limit");
    err_to++;
    finish_run();
  end

  initial begin
    logic [15:0] p;
    logic [15:0] v;
    rst_n = 1'b0;
    awaddr = '0;
    araddr = '0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    wait_frames(3);   // idle frames
    axi_read(`PSG_REG_CTRL, 0, RESP_OKAY, 32'h0);

    // register access with strobes and back-pressure
    axi_write(`PSG_REG_CH1, 32'h0003_0ABC, 4'hF, 3, RESP_OKAY);
    axi_read(`PSG_REG_CH1, 3, RESP_OKAY, 32'h0003_0ABC);
    axi_write(`PSG_REG_CH1, 32'hFFFF_F123, 4'h1, 0, RESP_OKAY);
    axi_read(`PSG_REG_CH1, 0, RESP_OKAY, 32'h0003_0A23);
    axi_write(`PSG_REG_CH2, 32'h0002_0500, 4'h6, 2, RESP_OKAY);
    axi_read(`PSG_REG_CH2, 0, RESP_OKAY, 32'h0002_0500);
    axi_write(`PSG_REG_CTRL, 32'hFFFF_FFFF, 4'h0, 0, RESP_OKAY);
    axi_read(`PSG_REG_CTRL, 0, RESP_OKAY, 32'h0);
    axi_write(6'h14, 32'hFFFF_FFFF, 4'hF, 2, RESP_SLVERR);
    axi_read(6'h14, 2, RESP_SLVERR, 32'h0);
    axi_read(6'h02, 0, RESP_SLVERR, 32'h0);

    // single tone on channel 0
    axi_write(`PSG_REG_CH0, 32'h0003_0002, 4'hF, 0, RESP_OKAY);
    axi_write(`PSG_REG_CTRL, 32'h1, 4'h1, 0, RESP_OKAY);
    wait_frames(12);

    // three random tones
    repeat (2) begin
      for (int i = 0; i < 3; i++) begin
        rand_bits(3, p);
        rand_bits(2, v);
        axi_write(6'(4 * (i + 1)), {14'h0, v[1:0], 4'h0, p[11:0]}, 4'hF, 0, RESP_OKAY);
      end
      axi_write(`PSG_REG_CTRL, 32'h7, 4'h1, 0, RESP_OKAY);
      wait_frames(16);
    end

    // noise alone and then with the tones
    axi_write(`PSG_REG_CTRL, 32'h0, 4'h1, 0, RESP_OKAY);
    axi_write(`PSG_REG_CH3, 32'h0003_0000, 4'hF, 0, RESP_OKAY);
    axi_write(`PSG_REG_CTRL, 32'h8, 4'h1, 0, RESP_OKAY);
    wait_frames(20);
    axi_write(`PSG_REG_CTRL, 32'hF, 4'h1, 0, RESP_OKAY);
    wait_frames(16);

    // disable and re-key
    axi_write(`PSG_REG_CTRL, 32'h7, 4'h1, 0, RESP_OKAY);
    wait_frames(4);
    axi_write(`PSG_REG_CTRL, 32'hA, 4'h1, 0, RESP_OKAY);
    wait_frames(8);
    finish_run();
  end

endmodule

/* flist.f */
+incdir+logic
logic/psg_pkg.sv
logic/psg_chan_if.sv
logic/psg_axil_regs.sv
logic/psg_tone_bank.sv
logic/psg_noise_chan.sv
logic/psg_pwm_mixer.sv
logic/psg_top.sv
sim/psg_chk.sv
sim/psg_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the psg testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert --top-module psg_tb -f flist.f -o psg_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/psg_sim > sim.log 2>&1 ; cat sim.log

grep -qx "sim passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
